// ==== verilog/sb_defines.svh ====
// scoreboard sizing macros
// ring depth, write-back port count and register/data widths

`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// --------------------
// ring
// --------------------
// depth of the entry ring, must be a power of two
`define SB_NR_ENTRIES 8

// number of functional unit write-back ports
`define SB_NR_WB_PORTS 2

// --------------------
// register file
// --------------------
`define SB_REG_ADDR_BITS 5
`define SB_NR_REGS 32

// data word width
`define SB_XLEN 32

`endif

// ==== verilog/sb_instr_pkg.sv ====
// scoreboard instruction types
// describes a decoded instruction, the functional units and
// the entry that the ring keeps for every instruction in flight

`include "sb_defines.svh"

package sb_instr_pkg;

  // --------------------
  // basic widths
  // --------------------
  typedef logic [`SB_REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`SB_XLEN-1:0] xlen_t;
  // ring index, doubles as transaction id
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // functional units, NONE finishes without write-back
  typedef enum logic [2:0] {
    NONE   = 3'd0,
    ALU    = 3'd1,
    LOAD   = 3'd2,
    STORE  = 3'd3,
    MULT   = 3'd4,
    BRANCH = 3'd5
  } fu_t;

  // --------------------
  // instruction records
  // --------------------
  // decoded instruction as handed over by decode
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
  } sb_instr_t;

  // one ring slot
  typedef struct packed {
    logic      issued;
    logic      valid;     // result is there
    logic      ex_valid;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
  } sb_entry_t;

  // clobbering unit for every general register
  typedef fu_t [`SB_NR_REGS-1:0] fu_map_t;

endpackage

// ==== verilog/sb_port_pkg.sv ====
// scoreboard port bundles
// write-back, commit and operand read structs plus the ring
// image that the store hands to the clobber map and forwarding

`include "sb_defines.svh"

package sb_port_pkg;

  import sb_instr_pkg::*;

  // --------------------
  // write-back
  // --------------------
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
  } sb_wb_t;

  // port 0 sits in the low slice
  typedef sb_wb_t [`SB_NR_WB_PORTS-1:0] sb_wb_bus_t;

  // oldest entry as seen by commit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    logic      ex_valid;
  } sb_commit_t;

  // --------------------
  // operand read
  // --------------------
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
  } sb_rd_req_t;

  typedef struct packed {
    logic  rs1_valid;
    xlen_t rs1_data;
    logic  rs2_valid;
    xlen_t rs2_data;
  } sb_rd_rsp_t;

  // full ring image, index is the trans id
  typedef sb_entry_t [`SB_NR_ENTRIES-1:0] entry_ring_t;

endpackage

// ==== verilog/sb_entry_store.sv ====
// scoreboard entry ring
// accepts decoded instructions, records write-back results,
// presents the oldest entry to commit and clears everything on flush

`timescale 1ns/1ps

`include "sb_defines.svh"

module sb_entry_store
  import sb_instr_pkg::*;
  import sb_port_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // decode side
  input  sb_instr_t   decoded_instr_i,
  input  logic        decoded_valid_i,
  output logic        decoded_ack_o,
  // issue side
  output sb_instr_t   issue_instr_o,
  output trans_id_t   issue_trans_id_o,
  output logic        issue_valid_o,
  input  logic        issue_ack_i,
  // functional units
  input  sb_wb_bus_t  wb_i,
  // commit side
  output sb_commit_t  commit_o,
  input  logic        commit_ack_i,
  input  logic        flush_i,
  output logic        sb_full_o,
  output entry_ring_t ring_o
);

  localparam int unsigned IdxBits = $clog2(`SB_NR_ENTRIES);

  entry_ring_t      ring_q, ring_n;
  trans_id_t        issue_ptr_q, issue_ptr_n;
  trans_id_t        commit_ptr_q, commit_ptr_n;
  // one bit wider than the index, msb set means full
  logic [IdxBits:0] cnt_q, cnt_n;
  logic             sb_full;
  logic             issue_en;

  assign sb_full   = cnt_q[IdxBits];
  assign sb_full_o = sb_full;
  assign ring_o    = ring_q;

  // --------------------
  // issue handshake
  // --------------------
  // trans id of an accepted instruction is the current issue pointer
  assign issue_instr_o    = decoded_instr_i;
  assign issue_trans_id_o = issue_ptr_q;
  assign issue_valid_o    = decoded_valid_i & ~sb_full;
  assign decoded_ack_o    = issue_ack_i & ~sb_full;
  assign issue_en         = decoded_valid_i & decoded_ack_o;

  // oldest entry, valid once issued and finished
  always_comb begin : commit_view
    commit_o.valid    = ring_q[commit_ptr_q].issued & ring_q[commit_ptr_q].valid;
    commit_o.trans_id = commit_ptr_q;
    commit_o.fu       = ring_q[commit_ptr_q].fu;
    commit_o.rd       = ring_q[commit_ptr_q].rd;
    commit_o.result   = ring_q[commit_ptr_q].result;
    commit_o.ex_valid = ring_q[commit_ptr_q].ex_valid;
  end

  // --------------------
  // ring next state
  // --------------------
  // later steps override earlier ones
  always_comb begin : ring_update
    ring_n = ring_q;

    // new entry at the issue pointer, not finished yet
    if (issue_en) begin
      ring_n[issue_ptr_q].issued   = 1'b1;
      ring_n[issue_ptr_q].valid    = 1'b0;
      ring_n[issue_ptr_q].ex_valid = 1'b0;
      ring_n[issue_ptr_q].fu       = decoded_instr_i.fu;
      ring_n[issue_ptr_q].rd       = decoded_instr_i.rd;
      ring_n[issue_ptr_q].result   = '0;
    end

    // no unit will ever write these back, finish them one cycle after they show up
    for (int e = 0; e < `SB_NR_ENTRIES; e++) begin
      if (ring_q[e].issued && ring_q[e].fu == NONE) begin
        ring_n[e].valid = 1'b1;
      end
    end

    // write-back, late results for flushed entries are dropped
    for (int p = 0; p < `SB_NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && ring_q[wb_i[p].trans_id].issued) begin
        ring_n[wb_i[p].trans_id].valid    = 1'b1;
        ring_n[wb_i[p].trans_id].result   = wb_i[p].data;
        ring_n[wb_i[p].trans_id].ex_valid = wb_i[p].ex_valid;
      end
    end

    // retire the oldest entry
    if (commit_ack_i) begin
      ring_n[commit_ptr_q].issued = 1'b0;
      ring_n[commit_ptr_q].valid  = 1'b0;
    end

    if (flush_i) begin
      for (int e = 0; e < `SB_NR_ENTRIES; e++) begin
        ring_n[e].issued   = 1'b0;
        ring_n[e].valid    = 1'b0;
        ring_n[e].ex_valid = 1'b0;
      end
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_comb begin : ptr_update
    issue_ptr_n  = issue_ptr_q + trans_id_t'(issue_en);
    commit_ptr_n = commit_ptr_q + trans_id_t'(commit_ack_i);
    cnt_n        = cnt_q + {{IdxBits{1'b0}}, issue_en} - {{IdxBits{1'b0}}, commit_ack_i};
    if (flush_i) begin
      issue_ptr_n  = '0;
      commit_ptr_n = '0;
      cnt_n        = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      ring_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      ring_q       <= ring_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      cnt_q        <= cnt_n;
    end
  end

  // --------------------
  // checks
  // --------------------
  // commit stage may only retire a finished entry
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_o.valid)
    else $error("commit acknowledged while the oldest entry is not finished");

  // units must never report the same transaction in one cycle
  for (genvar i = 0; i < `SB_NR_WB_PORTS; i++) begin : gen_wb_chk
    for (genvar j = i + 1; j < `SB_NR_WB_PORTS; j++) begin : gen_wb_pair
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_i[i].valid && wb_i[j].valid) |-> (wb_i[i].trans_id != wb_i[j].trans_id))
        else $error("write-back ports %0d and %0d carry the same trans id", i, j);
    end
  end

endmodule

// ==== verilog/sb_clobber_map.sv ====
// register clobber map
// for every general register, the functional unit of the
// lowest-index issued entry that will write it

`timescale 1ns/1ps

`include "sb_defines.svh"

module sb_clobber_map
  import sb_instr_pkg::*;
  import sb_port_pkg::*;
(
  input  entry_ring_t ring_i,
  output fu_map_t     rd_clobber_o
);

  // one request bit per register and entry
  logic [`SB_NR_REGS-1:0][`SB_NR_ENTRIES-1:0] clobber_req;

  // --------------------
  // requests
  // --------------------
  always_comb begin : build_req
    clobber_req = '0;
    for (int e = 0; e < `SB_NR_ENTRIES; e++) begin
      if (ring_i[e].issued) begin
        clobber_req[ring_i[e].rd][e] = 1'b1;
      end
    end
    // x0 is never written
    clobber_req[0] = '0;
  end

  // --------------------
  // selection
  // --------------------
  // walk downwards so the lowest index is the last one to write
  always_comb begin : select_fu
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      rd_clobber_o[r] = NONE;
      for (int e = `SB_NR_ENTRIES - 1; e >= 0; e--) begin
        if (clobber_req[r][e]) begin
          rd_clobber_o[r] = ring_i[e].fu;
        end
      end
    end
  end

endmodule

// ==== verilog/sb_operand_fwd.sv ====
// operand forwarding
// answers rs1/rs2 reads from the write-back ports in the same cycle
// or from finished ring entries, ports first, then lowest index

`timescale 1ns/1ps

`include "sb_defines.svh"

module sb_operand_fwd
  import sb_instr_pkg::*;
  import sb_port_pkg::*;
(
  input  entry_ring_t ring_i,
  input  sb_wb_bus_t  wb_i,
  input  sb_rd_req_t  rd_req_i,
  output sb_rd_rsp_t  rd_rsp_o
);

  // index 0 is rs1, index 1 is rs2
  reg_addr_t rs_addr [2];
  logic      rs_hit  [2];
  xlen_t     rs_data [2];

  assign rs_addr[0] = rd_req_i.rs1;
  assign rs_addr[1] = rd_req_i.rs2;

  // --------------------
  // candidate selection
  // --------------------
  // lowest priority first, each later hit overrides the one before
  always_comb begin : select_src
    for (int k = 0; k < 2; k++) begin
      rs_hit[k]  = 1'b0;
      rs_data[k] = '0;

      // finished entries, highest index has the lowest priority
      for (int e = `SB_NR_ENTRIES - 1; e >= 0; e--) begin
        if (ring_i[e].issued && ring_i[e].valid && ring_i[e].rd == rs_addr[k]) begin
          rs_hit[k]  = 1'b1;
          rs_data[k] = ring_i[e].result;
        end
      end

      // write-back ports beat the ring, port 0 beats port 1
      // a faulting result is never forwarded
      for (int p = `SB_NR_WB_PORTS - 1; p >= 0; p--) begin
        if (wb_i[p].valid && !wb_i[p].ex_valid &&
            ring_i[wb_i[p].trans_id].rd == rs_addr[k]) begin
          rs_hit[k]  = 1'b1;
          rs_data[k] = wb_i[p].data;
        end
      end

      // x0 always comes from the register file
      if (rs_addr[k] == '0) begin
        rs_hit[k] = 1'b0;
      end
    end
  end

  // --------------------
  // response
  // --------------------
  assign rd_rsp_o.rs1_valid = rs_hit[0];
  assign rd_rsp_o.rs1_data  = rs_data[0];
  assign rd_rsp_o.rs2_valid = rs_hit[1];
  assign rd_rsp_o.rs2_data  = rs_data[1];

endmodule

// ==== verilog/scoreboard_top.sv ====
// instruction scoreboard
// tracks up to eight in-flight instructions between issue and commit,
// reports clobbered registers and forwards finished results

`timescale 1ns/1ps

`include "sb_defines.svh"

module scoreboard_top
  import sb_instr_pkg::*;
  import sb_port_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // decode and issue
  input  sb_instr_t  decoded_instr_i,
  input  logic       decoded_valid_i,
  output logic       decoded_ack_o,
  output sb_instr_t  issue_instr_o,
  output trans_id_t  issue_trans_id_o,
  output logic       issue_valid_o,
  input  logic       issue_ack_i,
  output logic       sb_full_o,
  // functional unit results
  input  sb_wb_bus_t wb_i,
  // commit
  output sb_commit_t commit_o,
  input  logic       commit_ack_i,
  input  logic       flush_i,
  // register status and operand read
  output fu_map_t    rd_clobber_o,
  input  sb_rd_req_t rd_req_i,
  output sb_rd_rsp_t rd_rsp_o
);

  // ring image shared by clobber map and forwarding
  entry_ring_t ring;

  // --------------------
  // entry ring
  // --------------------
  sb_entry_store u_entry_store (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .decoded_instr_i  (decoded_instr_i),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_ack_o    (decoded_ack_o),
    .issue_instr_o    (issue_instr_o),
    .issue_trans_id_o (issue_trans_id_o),
    .issue_valid_o    (issue_valid_o),
    .issue_ack_i      (issue_ack_i),
    .wb_i             (wb_i),
    .commit_o         (commit_o),
    .commit_ack_i     (commit_ack_i),
    .flush_i          (flush_i),
    .sb_full_o        (sb_full_o),
    .ring_o           (ring)
  );

  // --------------------
  // register status
  // --------------------
  sb_clobber_map u_clobber_map (
    .ring_i       (ring),
    .rd_clobber_o (rd_clobber_o)
  );

  // ports are looked at directly so a result forwards in its own cycle
  sb_operand_fwd u_operand_fwd (
    .ring_i   (ring),
    .wb_i     (wb_i),
    .rd_req_i (rd_req_i),
    .rd_rsp_o (rd_rsp_o)
  );

endmodule

// ==== verification/scoreboard_tb.sv ====
// scoreboard testbench
// runs the operations of a pattern file against the DUT and checks
// every response with a reference model of ring, clobber map and forwarding

`timescale 1ns/1ps

`include "sb_defines.svh"

module scoreboard_tb
  import sb_instr_pkg::*;
  import sb_port_pkg::*;
();

  localparam int unsigned TIMEOUT = 50;
  localparam int unsigned DEPTH   = `SB_NR_ENTRIES;

  logic       clk_i;
  logic       rst_ni;
  sb_instr_t  decoded_instr_i;
  logic       decoded_valid_i;
  logic       decoded_ack_o;
  sb_instr_t  issue_instr_o;
  trans_id_t  issue_trans_id_o;
  logic       issue_valid_o;
  logic       issue_ack_i;
  logic       sb_full_o;
  sb_wb_bus_t wb_i;
  sb_commit_t commit_o;
  logic       commit_ack_i;
  logic       flush_i;
  fu_map_t    rd_clobber_o;
  sb_rd_req_t rd_req_i;
  sb_rd_rsp_t rd_rsp_o;

  // --------------------
  // reference model
  // --------------------
  // per trans id, plus the in-flight order
  logic        m_busy [DEPTH];
  fu_t         m_fu   [DEPTH];
  reg_addr_t   m_rd   [DEPTH];
  logic        m_done [DEPTH];
  xlen_t       m_data [DEPTH];
  logic        m_exc  [DEPTH];
  int unsigned m_acc  [DEPTH];
  trans_id_t   inflight_q [$];
  trans_id_t   m_issue_ptr;
  trans_id_t   m_commit_ptr;
  int unsigned cyc = 0;
  logic [31:0] lcg_state = 32'd41;

  scoreboard_top uut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .decoded_instr_i  (decoded_instr_i),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_ack_o    (decoded_ack_o),
    .issue_instr_o    (issue_instr_o),
    .issue_trans_id_o (issue_trans_id_o),
    .issue_valid_o    (issue_valid_o),
    .issue_ack_i      (issue_ack_i),
    .sb_full_o        (sb_full_o),
    .wb_i             (wb_i),
    .commit_o         (commit_o),
    .commit_ack_i     (commit_ack_i),
    .flush_i          (flush_i),
    .rd_clobber_o     (rd_clobber_o),
    .rd_req_i         (rd_req_i),
    .rd_rsp_o         (rd_rsp_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // edge count, used for the delayed finish of fu NONE entries
  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic xlen_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // fu NONE finishes one edge after it shows up in the ring
  function automatic logic entry_done(input int t);
    return m_busy[t] && (m_done[t] || (m_fu[t] == NONE && cyc >= m_acc[t] + 1));
  endfunction

  // lowest index writer wins, x0 never has one
  function automatic fu_map_t exp_clobber();
    fu_map_t map;
    for (int r = 0; r < `SB_NR_REGS; r++) begin
      map[r] = NONE;
    end
    for (int t = DEPTH - 1; t >= 0; t--) begin
      if (m_busy[t] && m_rd[t] != '0) begin
        map[m_rd[t]] = m_fu[t];
      end
    end
    return map;
  endfunction

  // port first, then finished entries by ascending trans id
  task automatic fwd_expect(input reg_addr_t rs, input logic wbv, input trans_id_t wbt,
                            input xlen_t wbd, input logic wbe,
                            output logic v, output xlen_t d);
    v = 1'b0;
    d = '0;
    if (wbv && !wbe && m_rd[wbt] == rs) begin
      v = 1'b1;
      d = wbd;
    end
    for (int t = 0; t < DEPTH; t++) begin
      if (!v && entry_done(t) && m_rd[t] == rs) begin
        v = 1'b1;
        d = m_data[t];
      end
    end
    if (rs == '0) v = 1'b0;
  endtask

  task automatic check_reads(input logic wbv, input trans_id_t wbt, input xlen_t wbd,
                             input logic wbe);
    logic  v;
    xlen_t d;
    fwd_expect(rd_req_i.rs1, wbv, wbt, wbd, wbe, v, d);
    check_value("rd_rsp_o.rs1_valid", 128'(rd_rsp_o.rs1_valid), 128'(v));
    if (v) check_value("rd_rsp_o.rs1_data", 128'(rd_rsp_o.rs1_data), 128'(d));
    fwd_expect(rd_req_i.rs2, wbv, wbt, wbd, wbe, v, d);
    check_value("rd_rsp_o.rs2_valid", 128'(rd_rsp_o.rs2_valid), 128'(v));
    if (v) check_value("rd_rsp_o.rs2_data", 128'(rd_rsp_o.rs2_data), 128'(d));
  endtask

  // outputs that depend on registered state only
  task automatic check_state();
    check_value("sb_full_o", 128'(sb_full_o), 128'(inflight_q.size() == DEPTH));
    check_value("commit_o.valid", 128'(commit_o.valid),
                128'(inflight_q.size() != 0 && entry_done(int'(m_commit_ptr))));
    check_value("rd_clobber_o", 128'(rd_clobber_o), 128'(exp_clobber()));
  endtask

  // --------------------
  // operations
  // --------------------
  task automatic issue_instr(input fu_t fu, input reg_addr_t rd);
    int unsigned n;
    sb_instr_t   instr;
    n         = 0;
    instr.fu  = fu;
    instr.rd  = rd;
    instr.rs1 = reg_addr_t'(next_random());
    instr.rs2 = reg_addr_t'(next_random());
    decoded_instr_i = instr;
    decoded_valid_i = 1'b1;
    issue_ack_i     = 1'b1;
    @(negedge clk_i);
    while (!(issue_valid_o && decoded_ack_o)) begin
      if (n >= TIMEOUT) begin
        fail_run("timed out waiting for the scoreboard to accept an instruction");
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
    check_value("issue_trans_id_o", 128'(issue_trans_id_o), 128'(m_issue_ptr));
    check_value("issue_instr_o", 128'(issue_instr_o), 128'(instr));
    @(posedge clk_i);
    #1;
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
    m_busy[m_issue_ptr] = 1'b1;
    m_fu[m_issue_ptr]   = fu;
    m_rd[m_issue_ptr]   = rd;
    m_done[m_issue_ptr] = 1'b0;
    m_data[m_issue_ptr] = '0;
    m_exc[m_issue_ptr]  = 1'b0;
    m_acc[m_issue_ptr]  = cyc;
    inflight_q.push_back(m_issue_ptr);
    m_issue_ptr++;
  endtask

  // reads the target register in the same cycle as the write-back
  task automatic write_back(input int port, input int offset, input logic exc);
    trans_id_t tid;
    xlen_t     data;
    tid  = m_commit_ptr + trans_id_t'(offset);
    data = next_random();
    wb_i[port].valid    = 1'b1;
    wb_i[port].trans_id = tid;
    wb_i[port].data     = data;
    wb_i[port].ex_valid = exc;
    rd_req_i.rs1 = m_rd[tid];
    rd_req_i.rs2 = '0;
    @(negedge clk_i);
    check_reads(1'b1, tid, data, exc);
    @(posedge clk_i);
    #1;
    wb_i = '0;
    m_done[tid] = 1'b1;
    m_data[tid] = data;
    m_exc[tid]  = exc;
  endtask

  task automatic commit_head();
    int unsigned n;
    trans_id_t   tid;
    n = 0;
    while (!commit_o.valid) begin
      if (n >= TIMEOUT) begin
        fail_run("timed out waiting for the oldest entry to become committable");
      end else begin
        @(posedge clk_i);
        #1;
        n++;
      end
    end
    tid = inflight_q.pop_front();
    check_value("commit_o.trans_id", 128'(commit_o.trans_id), 128'(tid));
    check_value("commit_o.fu", 128'(commit_o.fu), 128'(m_fu[tid]));
    check_value("commit_o.rd", 128'(commit_o.rd), 128'(m_rd[tid]));
    check_value("commit_o.result", 128'(commit_o.result), 128'(m_data[tid]));
    check_value("commit_o.ex_valid", 128'(commit_o.ex_valid), 128'(m_exc[tid]));
    commit_ack_i = 1'b1;
    @(posedge clk_i);
    #1;
    commit_ack_i = 1'b0;
    m_busy[tid]  = 1'b0;
    m_commit_ptr++;
  endtask

  task automatic read_regs(input reg_addr_t rs1, input reg_addr_t rs2);
    rd_req_i.rs1 = rs1;
    rd_req_i.rs2 = rs2;
    @(negedge clk_i);
    check_reads(1'b0, '0, '0, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  // issue until full, then hold one more instruction against back-pressure
  task automatic fill_ring();
    while (inflight_q.size() < DEPTH) begin
      issue_instr(fu_t'(3'(32'd1 + next_random() % 32'd5)), reg_addr_t'(next_random()));
    end
    check_state();
    decoded_instr_i.fu = ALU;
    decoded_instr_i.rd = 5'd1;
    decoded_valid_i    = 1'b1;
    issue_ack_i        = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_value("decoded_ack_o", 128'(decoded_ack_o), 128'(1'b0));
      check_value("issue_valid_o", 128'(issue_valid_o), 128'(1'b0));
    end
    @(posedge clk_i);
    #1;
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
  endtask

  task automatic flush_ring();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    for (int t = 0; t < DEPTH; t++) begin
      m_busy[t] = 1'b0;
    end
    inflight_q.delete();
    m_issue_ptr  = '0;
    m_commit_ptr = '0;
  endtask

  task automatic decode_fu(input logic [127:0] name, output fu_t fu);
    fu = NONE;
    if (name == 128'("alu")) fu = ALU;
    else if (name == 128'("load")) fu = LOAD;
    else if (name == 128'("store")) fu = STORE;
    else if (name == 128'("mult")) fu = MULT;
    else if (name == 128'("branch")) fu = BRANCH;
    else if (name != 128'("none")) fail_run("unknown functional unit in the pattern file");
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int                 fd;
    int                 code;
    int                 a;
    int                 b;
    int                 c;
    logic [127:0]       kw;
    logic [127:0]       name;
    logic [8*200-1:0]   line_buf;
    logic               done;
    fu_t                fu;
    rst_ni          = 1'b0;
    decoded_instr_i = '0;
    decoded_valid_i = 1'b0;
    issue_ack_i     = 1'b0;
    wb_i            = '0;
    commit_ack_i    = 1'b0;
    flush_i         = 1'b0;
    rd_req_i        = '0;
    for (int t = 0; t < DEPTH; t++) begin
      m_busy[t] = 1'b0;
      m_done[t] = 1'b0;
      m_rd[t]   = '0;
    end
    m_issue_ptr  = '0;
    m_commit_ptr = '0;
    fd = $fopen("verification/scoreboard_patterns.txt", "r");
    if (fd == 0) fail_run("cannot open the pattern file");

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check_value("issue_valid_o", 128'(issue_valid_o), 128'(1'b0));
    check_state();
    read_regs(5'd5, 5'd9);

    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", kw);
      if (code != 1) begin
        done = 1'b1;
      end else if (kw == 128'("#")) begin
        code = $fgets(line_buf, fd);
      end else if (kw == 128'("issue")) begin
        code = $fscanf(fd, "%s %d", name, a);
        decode_fu(name, fu);
        issue_instr(fu, reg_addr_t'(a));
      end else if (kw == 128'("wb")) begin
        code = $fscanf(fd, "%d %d %d", a, b, c);
        write_back(a, b, c[0]);
      end else if (kw == 128'("commit")) begin
        commit_head();
      end else if (kw == 128'("read")) begin
        code = $fscanf(fd, "%d %d", a, b);
        read_regs(reg_addr_t'(a), reg_addr_t'(b));
      end else if (kw == 128'("flush")) begin
        flush_ring();
      end else if (kw == 128'("fill")) begin
        fill_ring();
      end else if (kw == 128'("idle")) begin
        code = $fscanf(fd, "%d", a);
        repeat (a) begin
          @(posedge clk_i);
          #1;
        end
      end else begin
        fail_run("unknown operation in the pattern file");
      end
      check_state();
    end
    $fclose(fd);
    $display("No errors");
    $finish;
  end

endmodule

// ==== scoreboard_top.f ====
+incdir+verilog
verilog/sb_instr_pkg.sv
verilog/sb_port_pkg.sv
verilog/sb_entry_store.sv
verilog/sb_clobber_map.sv
verilog/sb_operand_fwd.sv
verilog/scoreboard_top.sv
verification/scoreboard_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module scoreboard_tb \
  -f scoreboard_top.f

# a fatal check ends the simulator with a non-zero status, keep its output
sim_out=$(./obj_dir/Vscoreboard_tb 2>&1) || true
echo "$sim_out"

if grep -qx "No errors" <<< "$sim_out"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

// ==== verification/scoreboard_patterns.txt ====
# operation keyword followed by its fields, wb slot offset counts from the oldest entry
# issue fu rd / wb port slot_offset exception / commit / read rs1 rs2 / flush / fill / idle n
issue alu 5
issue load 6
issue none 7
issue alu 0
issue mult 9
read 5 0
wb 1 1 0
read 6 5
wb 0 4 1
read 9 6
wb 0 0 0
commit
commit
commit
wb 1 0 0
commit
commit
read 9 7
fill
wb 1 0 0
commit
issue store 3
idle 2
flush
issue branch 12
wb 0 0 0
commit
